/* cpu.f */
design/cpu_pkg.sv
design/control_decode.sv
design/microsequencer.sv
design/alu.sv
design/datapath.sv
design/ram.sv
design/cpu.sv
tb/clock_gen.sv
tb/cpu_tb.sv

/* design/alu.sv */
// ----------------------------------------------------------
// zero/negate alu with add or and, flags latched on bus drive
// ----------------------------------------------------------
`timescale 1ns/1ns

module alu (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       alu_en,
    input  logic [5:0]                 alu_ctrl,
    input  logic [cpu_pkg::word_w-1:0] x,
    input  logic [cpu_pkg::word_w-1:0] y,
    output logic [cpu_pkg::word_w-1:0] result,
    output logic [2:0]                 flags
);
    import cpu_pkg::*;

    logic [word_w-1:0] xa, ya, fo;
    logic              carry;

    always_comb begin
        xa = alu_ctrl[u_ex - u_no] ? x : '0;    // ex gates x
        if (alu_ctrl[u_nx - u_no])
            xa = ~xa;
        ya = alu_ctrl[u_ey - u_no] ? y : '0;
        if (alu_ctrl[u_ny - u_no])
            ya = ~ya;
        if (alu_ctrl[u_f - u_no]) begin
            {carry, fo} = {1'b0, xa} + {1'b0, ya};
        end else begin
            carry = 1'b0;                       // no carry out of and
            fo    = xa & ya;
        end
        result = alu_ctrl[u_no - u_no] ? ~fo : fo;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            flags <= '0;
        end else if (alu_en) begin
            flags[flag_c] <= carry;
            flags[flag_z] <= (result == '0);
            flags[flag_n] <= result[word_w-1];
        end
    end

endmodule

/* design/control_decode.sv */
// ----------------------------------------------------------
// splits a microword into bus enables, load strobes and alu bits
// purely combinational, sits between sequencer and datapath
// ----------------------------------------------------------
`timescale 1ns/1ns

module control_decode (
    input  logic [15:0] uinstr,
    output logic        alu_en,
    output logic [5:0]  alu_ctrl,
    output logic        pc_out,
    output logic        iol_out,
    output logic        ram_out,
    output logic        dev_out,
    output logic        mar_in,
    output logic        ir_in,
    output logic        ram_in,
    output logic        x_in,
    output logic        y_in,
    output logic        dev_in,
    output logic        pc_inc,
    output logic        reset_step,
    output logic [3:0]  jump_mask
);
    import cpu_pkg::*;

    bus_src_e src;
    bus_dst_e dst;

    assign alu_en   = uinstr[u_alu_out];
    assign alu_ctrl = uinstr[u_ex:u_no];        // harmless when alu is off the bus
    assign src      = bus_src_e'(uinstr[u_src_hi:u_src_lo]);
    assign dst      = bus_dst_e'(uinstr[u_dst_hi:u_dst_lo]);

    // source enables, only without the alu
    assign pc_out  = !alu_en && (src == src_pc);
    assign iol_out = !alu_en && (src == src_ir_low);
    assign ram_out = !alu_en && (src == src_ram);
    assign dev_out = !alu_en && (src == src_dev);

    // destination strobes, dst_none loads nothing
    assign mar_in = (dst == dst_mar);
    assign ir_in  = (dst == dst_ir);
    assign ram_in = (dst == dst_ram);
    assign x_in   = (dst == dst_x);
    assign y_in   = (dst == dst_y);
    assign dev_in = (dst == dst_dev);

    // these bits mean ny / f on alu words
    assign reset_step = !alu_en && uinstr[u_rt];
    assign pc_inc     = !alu_en && uinstr[u_pc_inc];

    assign jump_mask = uinstr[u_jc:u_jlt];      // jc jz jgt jlt

    // a non-alu word must name a real bus source
    always_comb begin
        if (!uinstr[u_alu_out])
            assert (uinstr[u_src_hi:u_src_lo] inside {src_pc, src_ir_low, src_ram, src_dev})
                else $error("no bus source for uinstr %h", uinstr);
    end

endmodule

/* design/cpu.sv */
// ----------------------------------------------------------
// cpu top, wires the decoder, sequencer, alu, datapath and ram
// ----------------------------------------------------------
`timescale 1ns/1ns

module cpu #(
    parameter int ram_words = 256
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       prog_we,
    input  logic [7:0]                 prog_addr,
    input  logic [cpu_pkg::word_w-1:0] prog_data,
    input  logic [cpu_pkg::word_w-1:0] dev_rdata,
    output logic [cpu_pkg::word_w-1:0] out_data,
    output logic                       out_valid,
    output logic                       halted
);
    import cpu_pkg::*;

    logic [15:0]                  uinstr;
    logic                         alu_en;
    logic [5:0]                   alu_ctrl;
    logic                         pc_out, iol_out, ram_out, dev_out;
    logic                         mar_in, ir_in, ram_in, x_in, y_in, dev_in;
    logic                         pc_inc, reset_step;
    logic [3:0]                   jump_mask;
    logic [word_w-1:0]            bus, x, y, alu_result, ram_rdata;
    logic [2:0]                   flags;
    logic [$clog2(ram_words)-1:0] mar;
    opcode_e                      opcode;

    control_decode u_decode (
        .uinstr(uinstr), .alu_en(alu_en), .alu_ctrl(alu_ctrl),
        .pc_out(pc_out), .iol_out(iol_out), .ram_out(ram_out), .dev_out(dev_out),
        .mar_in(mar_in), .ir_in(ir_in), .ram_in(ram_in), .x_in(x_in), .y_in(y_in),
        .dev_in(dev_in), .pc_inc(pc_inc), .reset_step(reset_step),
        .jump_mask(jump_mask)
    );

    microsequencer u_seq (
        .clk(clk), .rst_n(rst_n), .opcode(opcode), .reset_step(reset_step),
        .uinstr(uinstr), .halted(halted)
    );

    alu u_alu (
        .clk(clk), .rst_n(rst_n), .alu_en(alu_en), .alu_ctrl(alu_ctrl),
        .x(x), .y(y), .result(alu_result), .flags(flags)
    );

    datapath #(.ram_words(ram_words)) u_dp (
        .clk(clk), .rst_n(rst_n),
        .pc_out(pc_out), .iol_out(iol_out), .ram_out(ram_out), .dev_out(dev_out),
        .mar_in(mar_in), .ir_in(ir_in), .x_in(x_in), .y_in(y_in), .dev_in(dev_in),
        .pc_inc(pc_inc), .jump_mask(jump_mask), .alu_en(alu_en),
        .alu_result(alu_result), .flags(flags), .ram_rdata(ram_rdata),
        .dev_rdata(dev_rdata), .bus(bus), .mar(mar), .x(x), .y(y),
        .opcode(opcode), .out_data(out_data), .out_valid(out_valid)
    );

    // ram writes come straight off the bus
    ram #(.ram_words(ram_words)) u_ram (
        .clk(clk), .addr(mar), .wdata(bus), .we(ram_in), .rdata(ram_rdata),
        .prog_we(prog_we), .prog_addr(prog_addr), .prog_data(prog_data)
    );

endmodule

/* design/cpu_pkg.sv */
// ----------------------------------------------------------
// shared opcodes, bus codes and microword layout for the cpu
// import into any block that decodes or builds microwords
// ----------------------------------------------------------
package cpu_pkg;

    localparam int word_w = 16;                 // data word width

    // instruction opcodes, high byte of the instruction word
    typedef enum logic [7:0] {
        op_halt    = 8'h00,
        op_ldx_imm = 8'h01,
        op_ldy_imm = 8'h02,
        op_add     = 8'h03,
        op_sub     = 8'h04,
        op_and     = 8'h05,
        op_ldx_mem = 8'h06,
        op_stx_mem = 8'h07,
        op_out     = 8'h08,
        op_in      = 8'h09,
        op_jz      = 8'h0a,
        op_jc      = 8'h0b,
        op_jmp     = 8'h0c
    } opcode_e;                                 // anything else runs as halt

    // bus sources, only when the alu is off the bus
    typedef enum logic [2:0] {
        src_pc      = 3'd0,
        src_ir_high = 3'd1,                     // reserved, no microcode
        src_ir_low  = 3'd2,
        src_ram     = 3'd3,
        src_dev     = 3'd6
    } bus_src_e;

    typedef enum logic [2:0] {
        dst_none = 3'd0,
        dst_mar  = 3'd1,
        dst_ir   = 3'd2,
        dst_ram  = 3'd3,
        dst_x    = 3'd4,
        dst_y    = 3'd5,
        dst_dev  = 3'd6
    } bus_dst_e;

    // microword bit positions
    localparam int u_alu_out = 15;
    localparam int u_ex      = 14;              // alu controls, bits 14..9
    localparam int u_nx      = 13;
    localparam int u_ey      = 12;
    localparam int u_ny      = 11;
    localparam int u_f       = 10;
    localparam int u_no      = 9;
    localparam int u_src_hi  = 14;              // overlaps ex..ey when alu_out clear
    localparam int u_src_lo  = 12;
    localparam int u_rt      = 11;              // reset_step, non-alu words only
    localparam int u_pc_inc  = 10;
    localparam int u_dst_hi  = 8;
    localparam int u_dst_lo  = 6;
    localparam int u_jc      = 5;               // jump mask, bits 5..2
    localparam int u_jlt     = 2;

    // flags word
    localparam int flag_c = 2;
    localparam int flag_z = 1;
    localparam int flag_n = 0;

endpackage

/* design/datapath.sv */
// ----------------------------------------------------------
// pc, ir, mar, x, y and the bus mux, plus jumps and the out port
// ----------------------------------------------------------
`timescale 1ns/1ns

module datapath #(
    parameter int ram_words = 256
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         pc_out,
    input  logic                         iol_out,
    input  logic                         ram_out,
    input  logic                         dev_out,
    input  logic                         mar_in,
    input  logic                         ir_in,
    input  logic                         x_in,
    input  logic                         y_in,
    input  logic                         dev_in,
    input  logic                         pc_inc,
    input  logic [3:0]                   jump_mask,
    input  logic                         alu_en,
    input  logic [cpu_pkg::word_w-1:0]   alu_result,
    input  logic [2:0]                   flags,
    input  logic [cpu_pkg::word_w-1:0]   ram_rdata,
    input  logic [cpu_pkg::word_w-1:0]   dev_rdata,
    output logic [cpu_pkg::word_w-1:0]   bus,
    output logic [$clog2(ram_words)-1:0] mar,
    output logic [cpu_pkg::word_w-1:0]   x,
    output logic [cpu_pkg::word_w-1:0]   y,
    output cpu_pkg::opcode_e             opcode,
    output logic [cpu_pkg::word_w-1:0]   out_data,
    output logic                         out_valid
);
    import cpu_pkg::*;

    localparam int aw = $clog2(ram_words);

    logic [aw-1:0]     pc;
    logic [word_w-1:0] ir;
    logic [3:0]        cond;                    // c z gt lt, mask order
    logic              pc_jump;

    assign opcode = opcode_e'(ir[15:8]);        // unknown codes pass through

    // bus mux, zero when idle
    always_comb begin
        if (alu_en)
            bus = alu_result;
        else if (pc_out)
            bus = word_w'(pc);
        else if (iol_out)
            bus = {8'h00, ir[7:0]};             // operand byte
        else if (ram_out)
            bus = ram_rdata;
        else if (dev_out)
            bus = dev_rdata;
        else
            bus = '0;
    end

    // conditions from the latched flags
    assign cond[3] = flags[flag_c];
    assign cond[2] = flags[flag_z];
    assign cond[1] = !flags[flag_z] && !flags[flag_n];  // gt
    assign cond[0] = flags[flag_n];                     // lt
    assign pc_jump = |(jump_mask & cond);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= '0;
            ir <= '0;                           // opcode feeds the sequencer
        end else begin
            if (pc_inc)
                pc <= pc + 1'b1;
            else if (pc_jump)
                pc <= bus[aw-1:0];
            if (ir_in)
                ir <= bus;
        end
    end

    // payload registers
    always_ff @(posedge clk) begin
        if (mar_in)
            mar <= bus[aw-1:0];
        if (x_in)
            x <= bus;
        if (y_in)
            y <= bus;
        if (dev_in)
            out_data <= bus;
    end

    always_ff @(posedge clk) begin
        if (!rst_n)
            out_valid <= 1'b0;
        else
            out_valid <= dev_in;                // one cycle per out
    end

    // microcode never jumps during fetch
    assert property (@(posedge clk) disable iff (!rst_n) !(pc_inc && pc_jump))
        else $error("pc_inc and jump in the same cycle");

endmodule

/* design/microsequencer.sv */
// ----------------------------------------------------------
// step counter plus microcode rom, fetch then execute per opcode
// latches halt on op_halt or an unknown opcode
// ----------------------------------------------------------
`timescale 1ns/1ns

module microsequencer (
    input  logic             clk,
    input  logic             rst_n,
    input  cpu_pkg::opcode_e opcode,
    input  logic             reset_step,
    output logic [15:0]      uinstr,
    output logic             halted
);
    import cpu_pkg::*;

    // alu controls ex nx ey ny f no
    localparam logic [5:0] alu_add = 6'b101010;  // x + y
    localparam logic [5:0] alu_sub = 6'b111011;  // ~(~x + y) = x - y
    localparam logic [5:0] alu_and = 6'b101000;
    localparam logic [5:0] alu_px  = 6'b100010;  // x + 0

    logic [2:0] step;
    logic       seq_end;                        // last step of an alu word
    logic       halt_hit;

    // plain bus move
    function automatic logic [15:0] mv(bus_src_e src, bus_dst_e dst, logic rt,
                                       logic pinc, logic [3:0] jm);
        logic [15:0] w;
        w = '0;
        w[u_src_hi:u_src_lo] = src;
        w[u_rt]              = rt;
        w[u_pc_inc]          = pinc;
        w[u_dst_hi:u_dst_lo] = dst;
        w[u_jc:u_jlt]        = jm;
        return w;
    endfunction

    // alu drives the bus
    function automatic logic [15:0] alu_w(logic [5:0] ctrl, bus_dst_e dst);
        logic [15:0] w;
        w = '0;
        w[u_alu_out]         = 1'b1;
        w[u_ex:u_no]         = ctrl;
        w[u_dst_hi:u_dst_lo] = dst;
        return w;
    endfunction

    always_comb begin
        uinstr   = '0;
        seq_end  = 1'b0;
        halt_hit = 1'b0;
        if (!halted) begin
            case (step)
                3'd0: uinstr = mv(src_pc, dst_mar, 1'b0, 1'b0, 4'b0000);
                3'd1: uinstr = mv(src_ram, dst_ir, 1'b0, 1'b1, 4'b0000);
                3'd2: begin
                    case (opcode)
                        op_ldx_imm: uinstr = mv(src_ir_low, dst_x, 1'b1, 1'b0, 4'b0000);
                        op_ldy_imm: uinstr = mv(src_ir_low, dst_y, 1'b1, 1'b0, 4'b0000);
                        op_add: begin
                            uinstr  = alu_w(alu_add, dst_x);
                            seq_end = 1'b1;
                        end
                        op_sub: begin
                            uinstr  = alu_w(alu_sub, dst_x);
                            seq_end = 1'b1;
                        end
                        op_and: begin
                            uinstr  = alu_w(alu_and, dst_x);
                            seq_end = 1'b1;
                        end
                        op_ldx_mem,
                        op_stx_mem: uinstr = mv(src_ir_low, dst_mar, 1'b0, 1'b0, 4'b0000);
                        op_out: begin
                            uinstr  = alu_w(alu_px, dst_dev);
                            seq_end = 1'b1;
                        end
                        op_in:  uinstr = mv(src_dev, dst_x, 1'b1, 1'b0, 4'b0000);
                        op_jz:  uinstr = mv(src_ir_low, dst_none, 1'b1, 1'b0, 4'b0100);
                        op_jc:  uinstr = mv(src_ir_low, dst_none, 1'b1, 1'b0, 4'b1000);
                        op_jmp: uinstr = mv(src_ir_low, dst_none, 1'b1, 1'b0, 4'b0111);
                        default: halt_hit = 1'b1;   // halt or unknown, zero word
                    endcase
                end
                3'd3: begin
                    if (opcode == op_ldx_mem) begin
                        uinstr = mv(src_ram, dst_x, 1'b1, 1'b0, 4'b0000);
                    end else if (opcode == op_stx_mem) begin
                        uinstr  = alu_w(alu_px, dst_ram);
                        seq_end = 1'b1;
                    end
                end
                default: uinstr = '0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            step   <= '0;
            halted <= 1'b0;
        end else begin
            if (halt_hit)
                halted <= 1'b1;
            if (halted || halt_hit)
                step <= step;                   // frozen
            else if (reset_step || seq_end)
                step <= '0;
            else
                step <= step + 3'd1;
        end
    end

    // ldx_mem / stx_mem are the longest, 4 steps
    assert property (@(posedge clk) disable iff (!rst_n) step <= 3'd3)
        else $error("step counter ran past 3");

endmodule

/* design/ram.sv */
// ----------------------------------------------------------
// main memory, async read, clocked write, program load port
// ----------------------------------------------------------
`timescale 1ns/1ns

module ram #(
    parameter int ram_words = 256
) (
    input  logic                         clk,
    input  logic [$clog2(ram_words)-1:0] addr,
    input  logic [cpu_pkg::word_w-1:0]   wdata,
    input  logic                         we,
    output logic [cpu_pkg::word_w-1:0]   rdata,
    input  logic                         prog_we,
    input  logic [7:0]                   prog_addr,
    input  logic [cpu_pkg::word_w-1:0]   prog_data
);
    import cpu_pkg::*;

    localparam int aw = $clog2(ram_words);

    logic [word_w-1:0] mem [ram_words];

    assign rdata = mem[addr];                   // read follows mar

    always_ff @(posedge clk) begin
        if (prog_we)
            mem[prog_addr[aw-1:0]] <= prog_data;   // loader wins
        else if (we)
            mem[addr] <= wdata;
    end

endmodule

/* run_sim.sh */
#!/bin/sh
# builds the cpu testbench with verilator, runs it and looks for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module cpu_tb -f cpu.f \
    --Mdir obj_dir -o cpu_tb_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/cpu_tb_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "sim passed"; then
    exit 0
fi
exit 1

/* tb/clock_gen.sv */
// ----------------------------------------------------------
// testbench clock, 8 ns period, power-on reset for 5 cycles
// ----------------------------------------------------------
`timescale 1ns/1ns

module clock_gen (
    output logic clk,
    output logic rst_n
);
    localparam int half_period  = 4;            // 8 ns clock
    localparam int reset_cycles = 5;

    initial begin
        clk = 1'b0;
        forever #half_period clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);                         // release away from the active edge
        rst_n = 1'b1;
    end

endmodule

/* tb/cpu_tb.sv */
// ----------------------------------------------------------
// directed tests for the cpu, each loads a program under reset,
// runs it to halt and compares the out port words
// ----------------------------------------------------------
`timescale 1ns/1ns

module cpu_tb;
    import cpu_pkg::*;

    localparam int tests_n         = 6;
    localparam int cycles_per_test = 200;
    localparam int timeout_cycles  = tests_n * cycles_per_test;
    localparam int settle_cycles   = 8;     // watch window after halt

    logic        clk;
    logic        por_rst_n;                 // from clock_gen
    logic        test_rst_n;                // per-test reset
    logic        prog_we;
    logic [7:0]  prog_addr;
    logic [15:0] prog_data;
    logic [15:0] dev_rdata;
    logic [15:0] out_data;
    logic        out_valid;
    logic        halted;

    logic [15:0] prog[$];                   // program image from address 0
    logic [15:0] expq[$];
    logic [15:0] gotq[$];

    int seed = 41085;
    int errors = 0;
    int checks = 0;
    int tests_run = 0;
    int cycles = 0;

    clock_gen u_clk (.clk(clk), .rst_n(por_rst_n));

    cpu #(.ram_words(256)) u_cpu (
        .clk(clk), .rst_n(por_rst_n && test_rst_n),
        .prog_we(prog_we), .prog_addr(prog_addr), .prog_data(prog_data),
        .dev_rdata(dev_rdata), .out_data(out_data), .out_valid(out_valid),
        .halted(halted)
    );

    always @(posedge clk)
        cycles <= cycles + 1;

    initial begin
        wait (cycles >= timeout_cycles);
        $display("timeout: the run did not finish within %0d cycles", timeout_cycles);
        $display("sim failed");
        $finish;
    end

    // opcode in the high byte, operand in the low byte
    function automatic logic [15:0] instr(logic [7:0] op, logic [7:0] arg);
        return {op, arg};
    endfunction

    task automatic check_equal(string name, logic [15:0] exp, logic [15:0] act);
        checks++;
        if (exp !== act) begin
            $display("error %s: expected %h actual %h", name, exp, act);
            errors++;
        end
    endtask

    // one program word per falling edge, prog_we left high
    task automatic poke(logic [7:0] addr, logic [15:0] data);
        @(negedge clk);
        prog_we   = 1'b1;
        prog_addr = addr;
        prog_data = data;
    endtask

    task automatic load_program();
        @(negedge clk);
        test_rst_n = 1'b0;                  // cpu held while ram fills
        for (int i = 0; i < prog.size(); i++)
            poke(8'(i), prog[i]);
    endtask

    task automatic sample_out();
        @(negedge clk);
        if (out_valid)
            gotq.push_back(out_data);
    endtask

    task automatic run_program();
        gotq.delete();
        @(negedge clk);
        prog_we    = 1'b0;                  // last poke landed on the rising edge
        test_rst_n = 1'b1;
        while (!halted)
            sample_out();
        repeat (settle_cycles)
            sample_out();                   // nothing may follow a halt
    endtask

    task automatic compare_outputs(string name);
        int n;
        n = (gotq.size() < expq.size()) ? gotq.size() : expq.size();
        if (gotq.size() != expq.size()) begin
            $display("%s: expected %0d output words but the cpu emitted %0d",
                     name, expq.size(), gotq.size());
            errors++;
        end
        for (int i = 0; i < n; i++)
            check_equal(name, expq[i], gotq[i]);
    endtask

    task automatic end_test(string name, int errs_before);
        tests_run++;
        if (errors == errs_before)
            $display("test %s ok", name);
        else
            $display("test %s: %0d errors", name, errors - errs_before);
    endtask

    task automatic test_add();
        int e0;
        logic [7:0] a, b;
        e0 = errors;
        a = 8'($random(seed));
        b = 8'($random(seed));
        prog = '{instr(op_ldx_imm, a), instr(op_ldy_imm, b), instr(op_add, 0),
                 instr(op_out, 0), instr(op_halt, 0)};
        expq = '{16'(a) + 16'(b)};          // carry into bit 8 kept
        load_program();
        run_program();
        compare_outputs("add");
        end_test("add", e0);
    endtask

    task automatic test_sub_and();
        int e0;
        logic [7:0] a, b;
        e0 = errors;
        a = 8'($random(seed));
        b = 8'($random(seed));
        prog = '{instr(op_ldx_imm, a), instr(op_ldy_imm, b), instr(op_sub, 0),
                 instr(op_out, 0), instr(op_ldx_imm, a), instr(op_and, 0),
                 instr(op_out, 0), instr(op_halt, 0)};
        expq = '{16'(a) - 16'(b), 16'(a & b)};  // 16-bit wrap on the difference
        load_program();
        run_program();
        compare_outputs("sub_and");
        end_test("sub_and", e0);
    endtask

    task automatic test_store_load();
        int e0;
        logic [7:0] v;
        e0 = errors;
        v = 8'($random(seed));
        prog = '{instr(op_ldx_imm, v), instr(op_stx_mem, 8'h80),
                 instr(op_ldx_imm, ~v), instr(op_ldx_mem, 8'h80),
                 instr(op_out, 0), instr(op_halt, 0)};
        expq = '{16'(v)};
        load_program();
        poke(8'h80, 16'hdead);              // stale data the store must replace
        run_program();
        compare_outputs("store_load");
        end_test("store_load", e0);
    endtask

    task automatic test_device_in();
        int e0;
        e0 = errors;
        prog = '{instr(op_in, 0), instr(op_out, 0), instr(op_halt, 0)};
        load_program();
        dev_rdata = 16'($random(seed));
        expq = '{dev_rdata};
        run_program();
        compare_outputs("device_in");
        end_test("device_in", e0);
    endtask

    task automatic test_jumps();
        int e0;
        e0 = errors;
        prog = '{
            instr(op_ldx_imm, 8'h05), instr(op_ldy_imm, 8'h05),
            instr(op_sub, 0),                       // 2: zero result
            instr(op_jz, 8'd6),                     // 3: taken
            instr(op_ldx_imm, 8'h11), instr(op_out, 0),
            instr(op_ldx_imm, 8'h22), instr(op_out, 0),     // 6, 7
            instr(op_ldy_imm, 8'h01), instr(op_sub, 0),     // 9: 0x21
            instr(op_jz, 8'd30),                    // 10: not taken
            instr(op_out, 0),                       // 11
            instr(op_ldx_imm, 8'h00), instr(op_ldy_imm, 8'h01),
            instr(op_sub, 0),                       // 14: 0 - 1
            instr(op_add, 0),                       // 15: +1 carries out
            instr(op_jc, 8'd19),                    // 16: taken
            instr(op_ldx_imm, 8'h33), instr(op_out, 0),
            instr(op_ldx_imm, 8'h44),               // 19
            instr(op_jmp, 8'd22),                   // 20: skips the out
            instr(op_out, 0),
            instr(op_ldx_imm, 8'h55), instr(op_out, 0), instr(op_halt, 0)
        };
        while (prog.size() < 30)
            prog.push_back(instr(op_halt, 0));
        prog.push_back(instr(op_ldx_imm, 8'hee));   // 30: wrong jz path
        prog.push_back(instr(op_out, 0));
        prog.push_back(instr(op_halt, 0));
        expq = '{16'h0022, 16'h0021, 16'h0055};
        load_program();
        run_program();
        compare_outputs("jumps");
        end_test("jumps", e0);
    endtask

    task automatic test_halt();
        int e0;
        e0 = errors;
        prog = '{instr(op_ldx_imm, 8'h5a), instr(op_out, 0), instr(op_halt, 0),
                 instr(op_out, 0)};
        expq = '{16'h005a};
        load_program();
        run_program();
        compare_outputs("halt");
        // unknown opcode stops the cpu the same way
        prog = '{instr(op_ldx_imm, 8'h66), instr(op_out, 0), instr(8'hff, 0),
                 instr(op_out, 0)};
        expq = '{16'h0066};
        load_program();
        run_program();
        compare_outputs("halt_unknown");
        check_equal("halt_unknown", 16'h0001, 16'(halted));  // still latched
        end_test("halt", e0);
    endtask

    initial begin
        test_rst_n = 1'b0;
        prog_we    = 1'b0;
        prog_addr  = '0;
        prog_data  = '0;
        dev_rdata  = '0;
        wait (por_rst_n);
        test_add();
        test_sub_and();
        test_store_load();
        test_device_in();
        test_jumps();
        test_halt();
        $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule
